//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := gpio_lite_tb
FILELIST  := sources.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/gpio_input_sync.sv
/*
 * pin input synchronizer
 * two flop stage per pin and a history flop
 * rising and falling edge pulses
 */

`timescale 1ns/1ps

module gpio_input_sync #(
   parameter int PIN_COUNT = 16
) (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic [PIN_COUNT-1:0]  pin_in,            // asynchronous to pclk
   output logic [PIN_COUNT-1:0]  pin_sync,          // second stage
   output logic [PIN_COUNT-1:0]  rise,              // one cycle pulse
   output logic [PIN_COUNT-1:0]  fall               // one cycle pulse
);

   logic [PIN_COUNT-1:0] meta;                      // first stage, may go metastable
   logic [PIN_COUNT-1:0] sync_q;                    // second stage
   logic [PIN_COUNT-1:0] prev_q;                    // sync value one cycle back

   // ------------------------------------------------------------------------
   // synchronizer chain
   // ------------------------------------------------------------------------

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         meta   <= '0;
         sync_q <= '0;
         prev_q <= '0;
      end
      else
      begin
         meta   <= pin_in;
         sync_q <= meta;
         prev_q <= sync_q;                          // history for edge detect
      end
   end

   assign pin_sync = sync_q;

   // edges compare new sync value against history
   assign rise = sync_q & ~prev_q;
   assign fall = ~sync_q & prev_q;

endmodule

//--- source/gpio_int_ctrl.sv
/*
 * gpio interrupt controller
 * per pin edge selection by polarity
 * sticky status bits, write one to clear, set wins
 * interrupt vector masked by the enable
 */

`timescale 1ns/1ps

module gpio_int_ctrl #(
   parameter int PIN_COUNT = 16
) (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic [PIN_COUNT-1:0]  rise,              // from the synchronizer
   input  logic [PIN_COUNT-1:0]  fall,
   input  logic [PIN_COUNT-1:0]  int_pol,           // 1 rising, 0 falling
   input  logic [PIN_COUNT-1:0]  int_en,
   input  logic [PIN_COUNT-1:0]  stat_clr,          // w1c pulse from regs
   output logic [PIN_COUNT-1:0]  int_stat,
   output logic [PIN_COUNT-1:0]  interrupt          // status & enable
);

   logic [PIN_COUNT-1:0] event_sel;                 // edge that counts per pin
   logic [PIN_COUNT-1:0] stat_next;

   // ------------------------------------------------------------------------
   // event selection
   // ------------------------------------------------------------------------

   // status is recorded whether or not the pin is enabled
   assign event_sel = (rise & int_pol) | (fall & ~int_pol);

   // ------------------------------------------------------------------------
   // sticky status
   // ------------------------------------------------------------------------

   always_comb
   begin
      stat_next = int_stat & ~stat_clr;             // clear first
      stat_next = stat_next | event_sel;            // new edge overrides clear
   end

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         int_stat <= '0;
      else
         int_stat <= stat_next;
   end

   // masked vector, the top level ORs it to one line
   assign interrupt = int_stat & int_en;

endmodule

//--- source/gpio_lite.sv
/*
 * gpio top level for an apb bus with up to 16 pins
 * apb phase decode into read and write strobes
 * zero fill of the unused read data bits
 * reduction of the per pin interrupts to one line
 */

`timescale 1ns/1ps

module gpio_lite #(
   parameter int PIN_COUNT = 16                     // number of io pins, 1 to 16
) (
   input  logic                  pclk,              // apb clock
   input  logic                  arst_n,            // async reset, active low
   input  logic                  psel,              // peripheral select
   input  logic                  penable,           // access phase
   input  logic                  pwrite,            // 1 for write transfers
   input  gpio_pkg::apb_addr_t   paddr,
   input  gpio_pkg::apb_data_t   pwdata,
   input  logic [PIN_COUNT-1:0]  gpio_pin_in,       // raw pin inputs, async
   input  logic [PIN_COUNT-1:0]  tri_state_enable,  // forces pin oe off
   output gpio_pkg::apb_data_t   prdata,
   output logic                  gpio_int,          // any enabled status bit
   output logic [PIN_COUNT-1:0]  n_gpio_pin_oe,     // active low output enable
   output logic [PIN_COUNT-1:0]  gpio_pin_out
);

   logic                  write;                    // write strobe, access phase
   logic                  read;                     // read strobe, setup phase
   gpio_pkg::apb_addr_t   addr;
   logic [PIN_COUNT-1:0]  wdata;
   logic [PIN_COUNT-1:0]  rdata;                    // registered in the subunit
   logic [PIN_COUNT-1:0]  interrupt_vec;            // masked status per pin

   // pin count range, caught at elaboration
   if ((PIN_COUNT < 1) || (PIN_COUNT > gpio_pkg::GPIO_MAX_PINS))
   begin : g_pin_count_check
      $fatal(1, "gpio_lite: PIN_COUNT must be between 1 and GPIO_MAX_PINS");
   end

   // ------------------------------------------------------------------------
   // apb decode
   // ------------------------------------------------------------------------

   assign write = psel & penable & pwrite;
   assign read  = psel & ~penable & ~pwrite;        // data is captured early
   assign addr  = paddr;
   assign wdata = pwdata[PIN_COUNT-1:0];            // upper bits unused

   // unused prdata bits tied low
   always_comb
   begin
      prdata                = '0;
      prdata[PIN_COUNT-1:0] = rdata;
   end

   assign gpio_int = |interrupt_vec;                // single irq line

   gpio_lite_subunit #(
      .PIN_COUNT         (PIN_COUNT)
   ) i_gpio_lite_subunit (
      .pclk              (pclk),
      .arst_n            (arst_n),
      .read              (read),
      .write             (write),
      .addr              (addr),
      .wdata             (wdata),
      .pin_in            (gpio_pin_in),
      .tri_state_enable  (tri_state_enable),
      .rdata             (rdata),
      .interrupt         (interrupt_vec),
      .pin_oe_n          (n_gpio_pin_oe),
      .pin_out           (gpio_pin_out)
   );

endmodule

//--- source/gpio_lite_subunit.sv
/*
 * gpio core, bus independent
 * register file, input synchronizer and interrupt controller
 * pin output and active low output enable with tri-state override
 */

`timescale 1ns/1ps

module gpio_lite_subunit #(
   parameter int PIN_COUNT = 16
) (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic                  read,              // read strobe
   input  logic                  write,             // write strobe
   input  gpio_pkg::apb_addr_t   addr,
   input  logic [PIN_COUNT-1:0]  wdata,
   input  logic [PIN_COUNT-1:0]  pin_in,            // straight from the pads
   input  logic [PIN_COUNT-1:0]  tri_state_enable,
   output logic [PIN_COUNT-1:0]  rdata,
   output logic [PIN_COUNT-1:0]  interrupt,         // per pin, masked
   output logic [PIN_COUNT-1:0]  pin_oe_n,
   output logic [PIN_COUNT-1:0]  pin_out
);

   // register file outputs
   logic [PIN_COUNT-1:0]  dir;                      // 1 = drive the pin
   logic [PIN_COUNT-1:0]  out_data;
   logic [PIN_COUNT-1:0]  int_en;
   logic [PIN_COUNT-1:0]  int_pol;
   logic [PIN_COUNT-1:0]  stat_clr;                 // w1c pulse

   // input path
   logic [PIN_COUNT-1:0]  pin_sync;
   logic [PIN_COUNT-1:0]  rise;
   logic [PIN_COUNT-1:0]  fall;

   logic [PIN_COUNT-1:0]  int_stat;                 // sticky status for readback

   // ------------------------------------------------------------------------
   // pin drive
   // ------------------------------------------------------------------------

   assign pin_out  = out_data;
   // enable only for outputs not held in tri-state by the pad ring
   assign pin_oe_n = ~(dir & ~tri_state_enable);

   gpio_regs #(
      .PIN_COUNT  (PIN_COUNT)
   ) i_gpio_regs (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .read       (read),
      .write      (write),
      .addr       (addr),
      .wdata      (wdata),
      .pin_sync   (pin_sync),
      .int_stat   (int_stat),
      .dir        (dir),
      .out_data   (out_data),
      .int_en     (int_en),
      .int_pol    (int_pol),
      .stat_clr   (stat_clr),
      .rdata      (rdata)
   );

   gpio_input_sync #(
      .PIN_COUNT  (PIN_COUNT)
   ) i_gpio_input_sync (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .pin_in     (pin_in),
      .pin_sync   (pin_sync),
      .rise       (rise),
      .fall       (fall)
   );

   gpio_int_ctrl #(
      .PIN_COUNT  (PIN_COUNT)
   ) i_gpio_int_ctrl (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .rise       (rise),
      .fall       (fall),
      .int_pol    (int_pol),
      .int_en     (int_en),
      .stat_clr   (stat_clr),
      .int_stat   (int_stat),
      .interrupt  (interrupt)
   );

endmodule

//--- source/gpio_pkg.sv
/*
 * shared definitions for the gpio peripheral
 * apb address and data word types
 * pin vector type and the pin count limit
 * register offsets of the gpio register map
 */

package gpio_pkg;

   // ------------------------------------------------------------------------
   // limits
   // ------------------------------------------------------------------------

   // widest pin bank the block supports, PIN_COUNT must not exceed it
   localparam int GPIO_MAX_PINS = 16;

   // ------------------------------------------------------------------------
   // bus and pin types
   // ------------------------------------------------------------------------

   typedef logic [5:0]  apb_addr_t;                 // byte address in the block
   typedef logic [31:0] apb_data_t;                 // full apb data word

   // pin-wide vector at max width
   // modules slice it down to PIN_COUNT
   typedef logic [GPIO_MAX_PINS-1:0] pin_vec_t;

   // ------------------------------------------------------------------------
   // register map
   // ------------------------------------------------------------------------

   localparam apb_addr_t ADDR_DIR      = 6'h00;     // 1 makes the pin an output
   localparam apb_addr_t ADDR_OUT      = 6'h04;     // output data
   localparam apb_addr_t ADDR_IN       = 6'h08;     // synced pin values, read only
   localparam apb_addr_t ADDR_INT_EN   = 6'h0C;     // per pin interrupt enable
   localparam apb_addr_t ADDR_INT_POL  = 6'h10;     // 1 rising, 0 falling
   localparam apb_addr_t ADDR_INT_STAT = 6'h14;     // sticky, write one to clear

   // all remaining offsets read as zero
   // and writes to them are dropped

endpackage

//--- source/gpio_regs.sv
/*
 * gpio register file
 * direction, output data, interrupt enable and polarity registers
 * write decode by offset and the status clear pulse
 * read multiplexer with registered read data
 */

`timescale 1ns/1ps

module gpio_regs #(
   parameter int PIN_COUNT = 16
) (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic                  read,              // setup phase of a read
   input  logic                  write,             // access phase of a write
   input  gpio_pkg::apb_addr_t   addr,
   input  logic [PIN_COUNT-1:0]  wdata,
   input  logic [PIN_COUNT-1:0]  pin_sync,          // ADDR_IN source
   input  logic [PIN_COUNT-1:0]  int_stat,          // ADDR_INT_STAT source
   output logic [PIN_COUNT-1:0]  dir,
   output logic [PIN_COUNT-1:0]  out_data,
   output logic [PIN_COUNT-1:0]  int_en,
   output logic [PIN_COUNT-1:0]  int_pol,
   output logic [PIN_COUNT-1:0]  stat_clr,          // one cycle, w1c
   output logic [PIN_COUNT-1:0]  rdata
);

   // per register write enables
   logic wr_dir;
   logic wr_out;
   logic wr_int_en;
   logic wr_int_pol;
   logic wr_int_stat;

   gpio_pkg::pin_vec_t rd_sel;                      // full width read mux

   // ------------------------------------------------------------------------
   // write decode
   // ------------------------------------------------------------------------

   assign wr_dir      = write && (addr == gpio_pkg::ADDR_DIR);
   assign wr_out      = write && (addr == gpio_pkg::ADDR_OUT);
   assign wr_int_en   = write && (addr == gpio_pkg::ADDR_INT_EN);
   assign wr_int_pol  = write && (addr == gpio_pkg::ADDR_INT_POL);
   assign wr_int_stat = write && (addr == gpio_pkg::ADDR_INT_STAT);

   // ones in the write data clear the matching status bits
   assign stat_clr = wr_int_stat ? wdata : '0;

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         dir      <= '0;                            // all pins start as inputs
         out_data <= '0;
         int_en   <= '0;
         int_pol  <= '0;
      end
      else
      begin
         if (wr_dir)
            dir <= wdata;
         if (wr_out)
            out_data <= wdata;
         if (wr_int_en)
            int_en <= wdata;
         if (wr_int_pol)
            int_pol <= wdata;
      end
   end

   // ------------------------------------------------------------------------
   // read path
   // ------------------------------------------------------------------------

   always_comb
   begin
      rd_sel = '0;                                  // unmapped offsets read 0
      case (addr)
         gpio_pkg::ADDR_DIR:      rd_sel[PIN_COUNT-1:0] = dir;
         gpio_pkg::ADDR_OUT:      rd_sel[PIN_COUNT-1:0] = out_data;
         gpio_pkg::ADDR_IN:       rd_sel[PIN_COUNT-1:0] = pin_sync;
         gpio_pkg::ADDR_INT_EN:   rd_sel[PIN_COUNT-1:0] = int_en;
         gpio_pkg::ADDR_INT_POL:  rd_sel[PIN_COUNT-1:0] = int_pol;
         gpio_pkg::ADDR_INT_STAT: rd_sel[PIN_COUNT-1:0] = int_stat;
         default:                 rd_sel = '0;
      endcase
   end

   // captured at the end of the setup phase
   // so prdata is steady for the whole access phase
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         rdata <= '0;
      else if (read)
         rdata <= rd_sel[PIN_COUNT-1:0];            // holds between reads
   end

endmodule

//--- sources.f
source/gpio_pkg.sv
source/gpio_input_sync.sv
source/gpio_int_ctrl.sv
source/gpio_regs.sv
source/gpio_lite_subunit.sv
source/gpio_lite.sv
tests/gpio_lite_props.sv
tests/gpio_lite_tb.sv

//--- tests/gpio_lite_props.sv
/*
 * concurrent checks on the gpio top level ports
 * read data upper half, reset output enables, tri-state override
 */

`timescale 1ns/1ps

module gpio_lite_props #(
   parameter int PIN_COUNT = 16
) (
   input logic                  pclk,
   input logic                  arst_n,
   input gpio_pkg::apb_data_t   prdata,
   input logic [PIN_COUNT-1:0]  n_gpio_pin_oe,
   input logic [PIN_COUNT-1:0]  tri_state_enable
);

   // pins never reach the upper half of the bus
   a_prdata_upper_zero: assert property (@(posedge pclk) prdata[31:16] == 16'h0)
      else $error("prdata upper half is not zero");

   // every pad floats while in reset
   a_oe_off_in_reset: assert property (@(posedge pclk) !arst_n |-> (&n_gpio_pin_oe))
      else $error("output enable active during reset");

   // tri-state request wins over dir
   a_tri_state_wins: assert property (@(posedge pclk)
      (n_gpio_pin_oe & tri_state_enable) == tri_state_enable)
      else $error("pin driven while tri_state_enable is set");

endmodule

bind gpio_lite gpio_lite_props #(
   .PIN_COUNT         (PIN_COUNT)
) i_gpio_lite_props (
   .pclk              (pclk),
   .arst_n            (arst_n),
   .prdata            (prdata),
   .n_gpio_pin_oe     (n_gpio_pin_oe),
   .tri_state_enable  (tri_state_enable)
);

//--- tests/gpio_lite_tb.sv
/*
 * testbench for the apb gpio block
 * clock, reset and xorshift stimulus on falling edges
 * register model, expected read values and prdata compare
 */

`timescale 1ns/1ps

module gpio_lite_tb;

   localparam int PINS       = 16;
   localparam int WAIT_LIMIT = 16;                  // cycles before a wait gives up

   logic                 pclk;
   logic                 arst_n;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   gpio_pkg::apb_addr_t  paddr;
   gpio_pkg::apb_data_t  pwdata;
   logic [PINS-1:0]      gpio_pin_in;
   logic [PINS-1:0]      tri_state_enable;
   gpio_pkg::apb_data_t  prdata;
   logic                 gpio_int;
   logic [PINS-1:0]      n_gpio_pin_oe;
   logic [PINS-1:0]      gpio_pin_out;

   // register model
   logic [PINS-1:0]      m_dir;
   logic [PINS-1:0]      m_out;
   logic [PINS-1:0]      m_int_en;
   logic [PINS-1:0]      m_int_pol;
   logic [PINS-1:0]      m_stat;
   logic [PINS-1:0]      m_pins;                    // last settled pin value
   gpio_pkg::apb_data_t  exp_rdata;                 // for the read in flight
   logic [31:0]          rng;
   int                   checks;
   int                   errors;
   int                   timeouts;

   gpio_lite #(
      .PIN_COUNT         (PINS)
   ) DUT (
      .pclk              (pclk),
      .arst_n            (arst_n),
      .psel              (psel),
      .penable           (penable),
      .pwrite            (pwrite),
      .paddr             (paddr),
      .pwdata            (pwdata),
      .gpio_pin_in       (gpio_pin_in),
      .tri_state_enable  (tri_state_enable),
      .prdata            (prdata),
      .gpio_int          (gpio_int),
      .n_gpio_pin_oe     (n_gpio_pin_oe),
      .gpio_pin_out      (gpio_pin_out)
   );

   initial
   begin
      pclk = 1'b0;
      forever #2 pclk = ~pclk;                      // 4 ns period
   end

   // ------------------------------------------------------------------------
   // random numbers and reference model
   // ------------------------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // expected prdata for an offset with upper bits zero
   function automatic gpio_pkg::apb_data_t expected_read(input gpio_pkg::apb_addr_t a);
      gpio_pkg::apb_data_t r;
      r = '0;
      case (a)
         gpio_pkg::ADDR_DIR:      r[PINS-1:0] = m_dir;
         gpio_pkg::ADDR_OUT:      r[PINS-1:0] = m_out;
         gpio_pkg::ADDR_IN:       r[PINS-1:0] = m_pins;
         gpio_pkg::ADDR_INT_EN:   r[PINS-1:0] = m_int_en;
         gpio_pkg::ADDR_INT_POL:  r[PINS-1:0] = m_int_pol;
         gpio_pkg::ADDR_INT_STAT: r[PINS-1:0] = m_stat;
         default:                 r = '0;   // unmapped
      endcase
      return r;
   endfunction

   // oe_n low only on an output pin that is not forced to tri-state
   function automatic logic [PINS-1:0] expected_oe_n(input logic [PINS-1:0] dir_v,
                                                     input logic [PINS-1:0] tse_v);
      logic [PINS-1:0] oe_n;
      oe_n = '1;                                    // every pad floats by default
      for (int p = 0; p < PINS; p++)
         if ((dir_v[p] == 1'b1) && (tse_v[p] == 1'b0))
            oe_n[p] = 1'b0;
      return oe_n;
   endfunction

   // status after a pin change with polarity picking the edge
   function automatic logic [PINS-1:0] next_stat(input logic [PINS-1:0] stat,
                                                 input logic [PINS-1:0] old_v,
                                                 input logic [PINS-1:0] new_v,
                                                 input logic [PINS-1:0] pol);
      logic [PINS-1:0] s;
      s = stat;
      for (int p = 0; p < PINS; p++)
      begin
         if (old_v[p] != new_v[p])
         begin
            // pol 1 wants the pin going high, pol 0 going low
            if (new_v[p] == pol[p])
               s[p] = 1'b1;
         end
      end
      return s;
   endfunction

   task automatic model_write(input gpio_pkg::apb_addr_t a, input logic [PINS-1:0] d);
      case (a)
         gpio_pkg::ADDR_DIR:      m_dir = d;
         gpio_pkg::ADDR_OUT:      m_out = d;
         gpio_pkg::ADDR_INT_EN:   m_int_en = d;
         gpio_pkg::ADDR_INT_POL:  m_int_pol = d;
         gpio_pkg::ADDR_INT_STAT: m_stat = m_stat & ~d;   // w1c
         default:                 ;                       // dropped
      endcase
   endtask

   // ------------------------------------------------------------------------
   // checks and bus tasks
   // ------------------------------------------------------------------------

   task automatic check_vec(input string what, input logic [PINS-1:0] got,
                            input logic [PINS-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_outputs();
      check_vec("gpio_pin_out", gpio_pin_out, m_out);
      check_vec("n_gpio_pin_oe", n_gpio_pin_oe, expected_oe_n(m_dir, tri_state_enable));
      checks++;
      if (gpio_int !== (|(m_stat & m_int_en)))
      begin
         errors++;
         $display("FAIL t=%0t gpio_int: got %b expected %b", $time, gpio_int,
                  |(m_stat & m_int_en));
      end
   endtask

   task automatic apb_write(input gpio_pkg::apb_addr_t a, input gpio_pkg::apb_data_t d);
      @(negedge pclk);
      psel    = 1'b1;                               // setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = d;
      @(negedge pclk);
      penable = 1'b1;                               // access phase lands on next edge
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      model_write(a, d[PINS-1:0]);
   endtask

   task automatic read_reg(input gpio_pkg::apb_addr_t a);
      @(negedge pclk);
      exp_rdata = expected_read(a);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = a;
      @(negedge pclk);
      penable = 1'b1;                               // compare runs in this phase
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_all_regs();
      for (int k = 0; k < 6; k++)
         read_reg(6'(k * 4));
   endtask

   // drive a new pin value and hold it until the status settles
   task automatic drive_pins(input logic [PINS-1:0] v);
      logic exp_int;
      int   n;
      gpio_pin_in = v;
      m_stat      = next_stat(m_stat, m_pins, v, m_int_pol);
      m_pins      = v;
      exp_int     = |(m_stat & m_int_en);
      n           = 0;
      while ((gpio_int !== exp_int) && (n < WAIT_LIMIT))
      begin
         @(negedge pclk);
         n++;
      end
      if (gpio_int !== exp_int)
      begin
         timeouts++;
         $display("timeout: gpio_int never reached %b after a pin change", exp_int);
      end
      while (n < 4)                                 // sync plus status edge
      begin
         @(negedge pclk);
         n++;
      end
   endtask

   // prdata is steady through the access phase
   always @(posedge pclk)
   begin
      if (arst_n && psel && penable && !pwrite)
      begin
         checks++;
         if (prdata !== exp_rdata)
         begin
            errors++;
            $display("FAIL t=%0t read of offset %h: prdata %h expected %h", $time, paddr,
                     prdata, exp_rdata);
         end
      end
   end

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   initial
   begin
      logic [31:0]         r;
      gpio_pkg::apb_addr_t a;
      arst_n           = 1'b0;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      exp_rdata        = '0;
      m_dir            = '0;
      m_out            = '0;
      m_int_en         = '0;
      m_int_pol        = '0;
      m_stat           = '0;
      m_pins           = '0;
      rng              = 32'd68939;
      repeat (2) @(posedge pclk);
      @(negedge pclk);
      arst_n = 1'b1;

      check_outputs();                              // reset state
      read_all_regs();

      for (int i = 0; i < 12; i++)                  // random write and readback
      begin
         r = next_rand();
         case (r[1:0])
            2'd0:    a = gpio_pkg::ADDR_DIR;
            2'd1:    a = gpio_pkg::ADDR_OUT;
            2'd2:    a = gpio_pkg::ADDR_INT_EN;
            default: a = gpio_pkg::ADDR_INT_POL;
         endcase
         apb_write(a, next_rand());
         @(negedge pclk);
         check_outputs();
         read_reg(a);
      end

      apb_write(gpio_pkg::ADDR_DIR, next_rand());   // tri-state override
      for (int i = 0; i < 8; i++)
      begin
         r = next_rand();
         tri_state_enable = r[PINS-1:0];
         @(negedge pclk);
         check_outputs();
      end
      tri_state_enable = '0;

      for (int i = 0; i < 8; i++)                   // input path
      begin
         r = next_rand();
         drive_pins(r[PINS-1:0]);
         read_reg(gpio_pkg::ADDR_IN);
      end

      apb_write(gpio_pkg::ADDR_INT_POL, next_rand());
      apb_write(gpio_pkg::ADDR_INT_EN, next_rand());
      apb_write(gpio_pkg::ADDR_INT_STAT, 32'hFFFF_FFFF);
      for (int i = 0; i < 16; i++)                  // edge interrupts
      begin
         r = next_rand();
         drive_pins(r[PINS-1:0]);
         check_outputs();
         read_reg(gpio_pkg::ADDR_INT_STAT);
         if (i % 3 == 2)
         begin
            apb_write(gpio_pkg::ADDR_INT_STAT, next_rand());
            @(negedge pclk);
            check_outputs();
            read_reg(gpio_pkg::ADDR_INT_STAT);
         end
      end

      apb_write(6'h18, next_rand());                // unmapped offsets
      apb_write(6'h2C, next_rand());
      apb_write(6'h3E, next_rand());
      read_reg(6'h18);
      read_reg(6'h1C);
      read_reg(6'h24);
      read_reg(6'h3C);
      read_reg(6'h02);
      read_all_regs();
      @(negedge pclk);
      check_outputs();

      repeat (2) @(negedge pclk);
      $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
